// File: source/biu_pkg.sv
`default_nettype none
//////////////////////////////////////////////////
// biu package
// bus enums, master and APB structs, sizing
// constants and the burst length decode
//////////////////////////////////////////////////

package biu_pkg;

  // sizing
  localparam int ADDR_SIZE      = 32;
  localparam int DATA_SIZE      = 32;
  localparam int STRB_SIZE      = DATA_SIZE / 8;        // one strobe per byte lane
  localparam int LANE_BITS      = $clog2(STRB_SIZE);    // byte offset inside a word
  localparam int PORTS          = 2;
  localparam int PORT_BITS      = (PORTS > 1) ? $clog2(PORTS) : 1;
  localparam int BEAT_BITS      = 4;                    // up to 16 beats
  localparam int RAM_WORDS      = 256;                  // 1 KiB at byte address 0
  localparam int RAM_AW         = $clog2(RAM_WORDS);
  localparam int PROT_BASE_WORD = 192;                  // upper quarter is protected

  typedef enum logic [1:0] {BYTE, HWORD, WORD, DWORD} biu_size_t;

  typedef enum logic [2:0] {
    SINGLE, INCR, WRAP4, INCR4, WRAP8, INCR8, WRAP16, INCR16
  } biu_type_t;

  // bit order matches APB pprot
  typedef struct packed {
    logic instr;   // pprot[2], instruction fetch
    logic nonsec;  // pprot[1], non-secure
    logic priv;    // pprot[0], privileged
  } biu_prot_t;

  typedef struct packed {
    logic                 req;
    logic [ADDR_SIZE-1:0] adr;    // burst start address
    biu_size_t            size;
    biu_type_t            btype;
    biu_prot_t            prot;
    logic                 we;
    logic [DATA_SIZE-1:0] d;      // write data, current beat
  } biu_req_t;

  typedef struct packed {
    logic                 req_ack; // burst accepted
    logic                 d_ack;   // write data sampled
    logic [ADDR_SIZE-1:0] adro;    // beat address
    logic [DATA_SIZE-1:0] q;
    logic                 ack;     // one per beat
    logic                 err;
  } biu_rsp_t;

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic [ADDR_SIZE-1:0] paddr;
    logic                 pwrite;
    logic [DATA_SIZE-1:0] pwdata;
    logic [STRB_SIZE-1:0] pstrb;
    biu_prot_t            pprot;
  } apb_req_t;

  typedef struct packed {
    logic                 pready;
    logic [DATA_SIZE-1:0] prdata;
    logic                 pslverr;
  } apb_rsp_t;

  // burst type to index of the last beat
  function automatic logic [BEAT_BITS-1:0] biu_last_beat(input biu_type_t btype);
    case (btype)
      WRAP4, INCR4:   return BEAT_BITS'(3);
      WRAP8, INCR8:   return BEAT_BITS'(7);
      WRAP16, INCR16: return BEAT_BITS'(15);
      default:        return BEAT_BITS'(0);   // SINGLE, INCR
    endcase
  endfunction

endpackage

`default_nettype wire

// File: source/biu_mux.sv
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////
// biu mux
// fixed priority arbiter, port 0 wins
// owning port is held for the whole burst
//////////////////////////////////////////////////

module biu_mux (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  // masters
  input  wire biu_pkg::biu_req_t mst_req_i [biu_pkg::PORTS],
  output biu_pkg::biu_rsp_t      mst_rsp_o [biu_pkg::PORTS],

  // shared channel to the bridge
  output biu_pkg::biu_req_t      biu_req_o,
  input  wire biu_pkg::biu_rsp_t biu_rsp_i
);

  import biu_pkg::*;

  typedef enum logic {ST_IDLE, ST_BUSY} state_t;

  state_t               state_q;
  logic                 any_req;     // some master wants the bus
  logic [PORT_BITS-1:0] sel_port;    // highest priority requester
  logic [PORT_BITS-1:0] own_port_q;  // port holding the burst
  logic [BEAT_BITS-1:0] beats_q;     // acks still to come, minus one

  //////////////////////////////////////////////////
  // arbitration

  // scan down so the lowest requesting port ends up selected
  always_comb
  begin
    any_req  = 1'b0;
    sel_port = '0;
    for (int n = PORTS - 1; n >= 0; n--)
    begin
      if (mst_req_i[n].req)
      begin
        any_req  = 1'b1;
        sel_port = PORT_BITS'(n);
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q    <= ST_IDLE;
      own_port_q <= '0;
      beats_q    <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (biu_rsp_i.req_ack)  // burst taken, lock the owner
          begin
            state_q    <= ST_BUSY;
            own_port_q <= sel_port;
            beats_q    <= biu_last_beat(mst_req_i[sel_port].btype);
          end
        end

        ST_BUSY:
        begin
          if (biu_rsp_i.ack)
          begin
            if (beats_q == '0)
              state_q <= ST_IDLE;    // last beat seen
            else
              beats_q <= beats_q - 1'b1;
          end
        end

        default: state_q <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // request path

  always_comb
  begin
    if (state_q == ST_IDLE)
    begin
      biu_req_o     = mst_req_i[sel_port];
      biu_req_o.req = any_req;
    end
    else
    begin
      // descriptor already latched by the bridge, only data moves now
      biu_req_o   = '0;
      biu_req_o.d = mst_req_i[own_port_q].d;
    end
  end

  //////////////////////////////////////////////////
  // response steering

  always_comb
  begin
    for (int p = 0; p < PORTS; p++)
    begin
      mst_rsp_o[p]      = '0;
      mst_rsp_o[p].adro = biu_rsp_i.adro;   // broadcast
      mst_rsp_o[p].q    = biu_rsp_i.q;      // broadcast
      if (state_q == ST_IDLE && sel_port == PORT_BITS'(p))
        mst_rsp_o[p].req_ack = biu_rsp_i.req_ack;
      if (state_q == ST_BUSY && own_port_q == PORT_BITS'(p))
      begin
        mst_rsp_o[p].d_ack = biu_rsp_i.d_ack;
        mst_rsp_o[p].ack   = biu_rsp_i.ack;
        mst_rsp_o[p].err   = biu_rsp_i.err;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/biu_apb_bridge.sv
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////
// biu to apb bridge
// splits a biu burst into single apb transfers
// beat address generation and byte strobes
//////////////////////////////////////////////////

module biu_apb_bridge (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  input  wire biu_pkg::biu_req_t biu_req_i,
  output biu_pkg::biu_rsp_t      biu_rsp_o,

  output biu_pkg::apb_req_t      apb_req_o,
  input  wire biu_pkg::apb_rsp_t apb_rsp_i
);

  import biu_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} state_t;

  state_t               state_q;
  logic [BEAT_BITS-1:0] beats_q;    // beats left, minus one
  logic [ADDR_SIZE-1:0] addr_q;     // current beat address
  biu_size_t            size_q;
  biu_type_t            btype_q;
  biu_prot_t            prot_q;
  logic                 we_q;
  logic                 bad_q;      // refused burst, no apb traffic
  logic [DATA_SIZE-1:0] wdata_q;    // beat data held through ACCESS
  logic [ADDR_SIZE-1:0] next_addr;
  logic                 beat_done;

  //////////////////////////////////////////////////
  // helpers

  function automatic logic [ADDR_SIZE-1:0] size2step(input biu_size_t size);
    return ADDR_SIZE'(1) << size;  // bytes per beat
  endfunction

  function automatic logic is_wrap(input biu_type_t btype);
    return (btype == WRAP4) || (btype == WRAP8) || (btype == WRAP16);
  endfunction

  // wrapping bursts stay in the block of beats*step bytes
  function automatic logic [ADDR_SIZE-1:0] beat_addr_next(
    input logic [ADDR_SIZE-1:0] addr,
    input biu_size_t            size,
    input biu_type_t            btype
  );
    logic [ADDR_SIZE-1:0] step;
    logic [ADDR_SIZE-1:0] mask;
    step = size2step(size);
    mask = ((ADDR_SIZE'(biu_last_beat(btype)) + 1'b1) << size) - 1'b1;
    if (is_wrap(btype))
      return (addr & ~mask) | ((addr + step) & mask);
    return addr + step;
  endfunction

  // DWORD does not fit the 32 bit bus
  function automatic logic refused(
    input biu_size_t            size,
    input logic [ADDR_SIZE-1:0] addr
  );
    return (size == DWORD) || ((addr & (size2step(size) - 1'b1)) != '0);
  endfunction

  function automatic logic [STRB_SIZE-1:0] size2strb(
    input biu_size_t            size,
    input logic [LANE_BITS-1:0] lane
  );
    case (size)
      BYTE:    return STRB_SIZE'(1) << lane;
      HWORD:   return STRB_SIZE'(3) << {lane[LANE_BITS-1:1], 1'b0};
      WORD:    return '1;
      default: return '0;   // never reaches the bus
    endcase
  endfunction

  //////////////////////////////////////////////////
  // sequencer

  assign beat_done = (state_q == ST_ACCESS) && (bad_q || apb_rsp_i.pready);
  assign next_addr = beat_addr_next(addr_q, size_q, btype_q);

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ST_IDLE;
      beats_q <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (biu_req_i.req)
          begin
            state_q <= ST_SETUP;
            beats_q <= biu_last_beat(biu_req_i.btype);
          end
        end
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS:
        begin
          if (beat_done)
          begin
            if (beats_q == '0)
              state_q <= ST_IDLE;
            else
            begin
              state_q <= ST_SETUP;   // next beat
              beats_q <= beats_q - 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // burst descriptor, latched on acceptance
  always_ff @(posedge clk_i)
  begin
    if (state_q == ST_IDLE && biu_req_i.req)
    begin
      addr_q  <= biu_req_i.adr;
      size_q  <= biu_req_i.size;
      btype_q <= biu_req_i.btype;
      prot_q  <= biu_req_i.prot;
      we_q    <= biu_req_i.we;
      bad_q   <= refused(biu_req_i.size, biu_req_i.adr);
    end
    else if (beat_done)
      addr_q <= next_addr;
    if (state_q == ST_SETUP)
      wdata_q <= biu_req_i.d;  // master moves on after d_ack
  end

  //////////////////////////////////////////////////
  // outputs

  always_comb
  begin
    apb_req_o.psel    = (state_q == ST_SETUP || state_q == ST_ACCESS) && !bad_q;
    apb_req_o.penable = (state_q == ST_ACCESS) && !bad_q;
    apb_req_o.paddr   = addr_q;
    apb_req_o.pwrite  = we_q;
    apb_req_o.pwdata  = (state_q == ST_SETUP) ? biu_req_i.d : wdata_q;
    apb_req_o.pstrb   = we_q ? size2strb(size_q, addr_q[LANE_BITS-1:0]) : '0;
    apb_req_o.pprot   = prot_q;

    biu_rsp_o.req_ack = (state_q == ST_IDLE) && biu_req_i.req;
    biu_rsp_o.d_ack   = (state_q == ST_SETUP) && we_q;
    biu_rsp_o.adro    = addr_q;
    biu_rsp_o.q       = apb_rsp_i.prdata;
    biu_rsp_o.ack     = beat_done;
    biu_rsp_o.err     = beat_done && (bad_q || apb_rsp_i.pslverr);
  end

endmodule

`default_nettype wire

// File: source/apb_ram.sv
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////
// apb ram
// word memory with byte strobes, one read wait
// state, range and privilege checks
//////////////////////////////////////////////////

module apb_ram (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire biu_pkg::apb_req_t apb_req_i,
  output biu_pkg::apb_rsp_t      apb_rsp_o
);

  import biu_pkg::*;

  localparam int WIDX_BITS = ADDR_SIZE - LANE_BITS;

  logic [DATA_SIZE-1:0] mem [RAM_WORDS];
  logic [WIDX_BITS-1:0] widx;       // full word index for the range check
  logic [RAM_AW-1:0]    ram_idx;
  logic                 access;     // ACCESS phase
  logic                 bad;        // out of range or protected
  logic                 rd_wait_q;  // read wait state spent
  logic [DATA_SIZE-1:0] rdata_q;

  assign widx    = apb_req_i.paddr[ADDR_SIZE-1:LANE_BITS];
  assign ram_idx = widx[RAM_AW-1:0];
  assign access  = apb_req_i.psel && apb_req_i.penable;

  // upper quarter needs the privileged bit
  assign bad = (widx >= WIDX_BITS'(RAM_WORDS))
            || (!apb_req_i.pprot.priv && widx >= WIDX_BITS'(PROT_BASE_WORD));

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      rd_wait_q <= 1'b0;
    else
      rd_wait_q <= access && !apb_req_i.pwrite && !bad && !rd_wait_q;
  end

  //////////////////////////////////////////////////
  // array

  always_ff @(posedge clk_i)
  begin
    if (access && !bad)
    begin
      if (apb_req_i.pwrite)
      begin
        for (int b = 0; b < STRB_SIZE; b++)
        begin
          if (apb_req_i.pstrb[b])
            mem[ram_idx][8*b +: 8] <= apb_req_i.pwdata[8*b +: 8];
        end
      end
      else if (!rd_wait_q)
        rdata_q <= mem[ram_idx];   // presented in the wait cycle
    end
  end

  always_comb
  begin
    apb_rsp_o.pready  = access && (apb_req_i.pwrite || bad || rd_wait_q);
    apb_rsp_o.prdata  = rdata_q;
    apb_rsp_o.pslverr = access && bad;
  end

endmodule

`default_nettype wire

// File: source/biu_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////
// biu memory subsystem top
// two masters, mux, apb bridge and apb ram
//////////////////////////////////////////////////

module biu_subsys_top (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire biu_pkg::biu_req_t mst_req_i [biu_pkg::PORTS],
  output biu_pkg::biu_rsp_t      mst_rsp_o [biu_pkg::PORTS]
);

  import biu_pkg::*;

  biu_req_t biu_req;   // arbitrated channel
  biu_rsp_t biu_rsp;
  apb_req_t apb_req;   // memory side
  apb_rsp_t apb_rsp;

  biu_mux u_biu_mux (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mst_req_i (mst_req_i),
    .mst_rsp_o (mst_rsp_o),
    .biu_req_o (biu_req),
    .biu_rsp_i (biu_rsp)
  );

  biu_apb_bridge u_biu_apb_bridge (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .biu_req_i (biu_req),
    .biu_rsp_o (biu_rsp),
    .apb_req_o (apb_req),
    .apb_rsp_i (apb_rsp)
  );

  apb_ram u_apb_ram (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

endmodule

`default_nettype wire

// File: test/biu_ref.svh
//////////////////////////////////////////////////
// biu reference model
// shadow memory plus expected beat address,
// read data and error status
//////////////////////////////////////////////////
`ifndef BIU_REF_SVH
`define BIU_REF_SVH

logic [DATA_SIZE-1:0] shadow [RAM_WORDS];  // holds expected-good writes only

// beats per burst type
function automatic int ref_beats(input biu_type_t btype);
  case (btype)
    WRAP4, INCR4:   return 4;
    WRAP8, INCR8:   return 8;
    WRAP16, INCR16: return 16;
    default:        return 1;   // SINGLE, INCR
  endcase
endfunction

// address of beat n, wrap keeps inside the aligned block of beats*step
function automatic logic [31:0] ref_addr(
  input logic [31:0] start,
  input biu_size_t   size,
  input biu_type_t   btype,
  input int          beat
);
  logic [31:0] step;
  logic [31:0] len;
  logic [31:0] base;
  step = 32'd1 << size;
  if (btype == WRAP4 || btype == WRAP8 || btype == WRAP16)
  begin
    len  = step * ref_beats(btype);
    base = start - (start % len);
    return base + ((start - base + beat * step) % len);
  end
  return start + beat * step;
endfunction

function automatic logic ref_err(
  input logic [31:0] addr,
  input biu_size_t   size,
  input logic        priv
);
  logic [31:0] word;
  word = addr >> 2;
  if (size == DWORD || (addr % (32'd1 << size)) != 0)
    return 1'b1;                              // refused by the bridge
  if (word >= RAM_WORDS)
    return 1'b1;                              // past the end of the ram
  return !priv && (word >= PROT_BASE_WORD);   // protected quarter
endfunction

// byte lanes written by one beat
function automatic logic [3:0] ref_lanes(input logic [31:0] addr, input biu_size_t size);
  case (size)
    BYTE:    return 4'b0001 << addr[1:0];
    HWORD:   return addr[1] ? 4'b1100 : 4'b0011;
    default: return 4'b1111;
  endcase
endfunction

function automatic void ref_write(
  input logic [31:0] addr,
  input biu_size_t   size,
  input logic [31:0] data
);
  logic [3:0] lanes;
  lanes = ref_lanes(addr, size);
  for (int b = 0; b < 4; b++)
  begin
    if (lanes[b])
      shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];  // merge into the word
  end
endfunction

function automatic logic [31:0] ref_read(input logic [31:0] addr);
  return shadow[addr[9:2]];
endfunction

`endif

// File: test/biu_subsys_tb.sv
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////
// biu subsystem testbench
// two master drivers, a beat checker against
// the reference model, directed test sequence
//////////////////////////////////////////////////

module biu_subsys_tb;

  import biu_pkg::*;

  `include "biu_ref.svh"

  localparam int TIMEOUT_CYCLES = 4000;  // generous bound, full sequence is about 300 cycles

  logic        clk_i;
  logic        rst_ni;
  biu_req_t    mst_req [PORTS];
  biu_rsp_t    mst_rsp [PORTS];
  integer      seed;
  int          n_checks;
  int          n_errors;
  int          err_mark;     // errors before the current test
  int          cycles;

  // per port burst in flight, filled by the driver
  logic [31:0] wbuf [PORTS][16];
  logic [31:0] cur_adr [PORTS];
  biu_size_t   cur_size [PORTS];
  biu_type_t   cur_type [PORTS];
  logic        cur_priv [PORTS];
  logic        cur_we [PORTS];
  logic        accepted [PORTS];
  int          beat_idx [PORTS];
  time         acc_time [PORTS];
  time         done_time [PORTS];

  biu_subsys_top u_biu_subsys_top (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mst_req_i (mst_req),
    .mst_rsp_o (mst_rsp)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, a burst never completed", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // compare and report

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp)
    begin
      n_errors++;
      $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-10s done, %0d errors", name, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  // one beat against the model, write beats update the shadow
  task automatic check_beat(input int p);
    logic [31:0] a;
    logic        e;
    a = ref_addr(cur_adr[p], cur_size[p], cur_type[p], beat_idx[p]);
    e = ref_err(a, cur_size[p], cur_priv[p]);
    check_val($sformatf("adro[%0d]", p), a, mst_rsp[p].adro);
    check_val($sformatf("err[%0d]", p), {31'b0, e}, {31'b0, mst_rsp[p].err});
    if (!e && cur_we[p])
      ref_write(a, cur_size[p], wbuf[p][beat_idx[p]]);
    else if (!e)
      check_val($sformatf("q[%0d]", p), ref_read(a), mst_rsp[p].q);
    beat_idx[p]++;
  endtask

  // outputs settle long before the falling edge
  always @(negedge clk_i)
  begin
    for (int p = 0; p < PORTS; p++)
    begin
      if (rst_ni && mst_rsp[p].ack)
      begin
        if (!accepted[p])
        begin
          n_errors++;
          $display("port %0d saw a beat ack with no accepted burst at %0t", p, $time);
        end
        else
          check_beat(p);
      end
    end
  end

  //////////////////////////////////////////////////
  // master driver, starts 2 ns after a rising edge

  task automatic run_burst(
    input int          p,
    input logic [31:0] adr,
    input biu_size_t   size,
    input biu_type_t   btype,
    input logic        priv,
    input logic        we
  );
    int   nbeats;
    int   beat_d;
    int   acks;
    logic dack;
    logic ack;
    nbeats = ref_beats(btype);
    for (int i = 0; i < 16; i++)
      wbuf[p][i] = $random(seed);
    cur_adr[p]  = adr;
    cur_size[p] = size;
    cur_type[p] = btype;
    cur_priv[p] = priv;
    cur_we[p]   = we;
    beat_idx[p] = 0;
    mst_req[p].adr   = adr;
    mst_req[p].size  = size;
    mst_req[p].btype = btype;
    mst_req[p].prot  = {2'b00, priv};
    mst_req[p].we    = we;
    mst_req[p].d     = wbuf[p][0];
    mst_req[p].req   = 1'b1;
    @(negedge clk_i);
    while (!mst_rsp[p].req_ack)   // descriptor held until accepted
      @(negedge clk_i);
    acc_time[p] = $time;
    accepted[p] = 1'b1;
    @(posedge clk_i);
    #2;
    mst_req[p].req = 1'b0;
    beat_d = 0;
    acks   = 0;
    while (acks < nbeats)
    begin
      @(negedge clk_i);
      dack = mst_rsp[p].d_ack;
      ack  = mst_rsp[p].ack;
      @(posedge clk_i);
      #2;
      if (dack && beat_d < 15)
      begin
        beat_d++;
        mst_req[p].d = wbuf[p][beat_d];  // next beat data after d_ack
      end
      if (ack)
        acks++;
    end
    done_time[p] = $time;
    accepted[p]  = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial
  begin
    seed     = 32'h3f0a;
    n_checks = 0;
    n_errors = 0;
    err_mark = 0;
    rst_ni   = 1'b0;
    for (int p = 0; p < PORTS; p++)
    begin
      mst_req[p]  = '0;
      accepted[p] = 1'b0;
      beat_idx[p] = 0;
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (int p = 0; p < PORTS; p++)
    begin
      check_val($sformatf("req_ack[%0d]", p), 32'd0, {31'b0, mst_rsp[p].req_ack});
      check_val($sformatf("d_ack[%0d]", p), 32'd0, {31'b0, mst_rsp[p].d_ack});
      check_val($sformatf("ack[%0d]", p), 32'd0, {31'b0, mst_rsp[p].ack});
    end
    report_test("reset");

    run_burst(0, 32'h010, WORD, SINGLE, 1'b0, 1'b1);
    run_burst(0, 32'h010, WORD, SINGLE, 1'b0, 1'b0);
    run_burst(1, 32'h014, WORD, SINGLE, 1'b0, 1'b1);
    run_burst(1, 32'h014, WORD, SINGLE, 1'b0, 1'b0);
    run_burst(1, 32'h010, WORD, SINGLE, 1'b0, 1'b0);  // cross port read
    report_test("single");

    run_burst(0, 32'h020, WORD, SINGLE, 1'b0, 1'b1);
    run_burst(1, 32'h021, BYTE, SINGLE, 1'b0, 1'b1);
    run_burst(0, 32'h022, HWORD, SINGLE, 1'b0, 1'b1);
    run_burst(1, 32'h020, BYTE, SINGLE, 1'b0, 1'b1);
    run_burst(0, 32'h020, WORD, SINGLE, 1'b0, 1'b0);  // merged word
    report_test("merge");

    run_burst(0, 32'h100, WORD, INCR16, 1'b0, 1'b1);
    run_burst(1, 32'h100, WORD, INCR16, 1'b0, 1'b0);
    run_burst(1, 32'h0c0, WORD, INCR4, 1'b0, 1'b1);
    run_burst(0, 32'h0c0, WORD, INCR4, 1'b0, 1'b0);
    run_burst(0, 32'h218, WORD, WRAP8, 1'b0, 1'b1);   // wraps at 0x220
    run_burst(1, 32'h208, WORD, WRAP8, 1'b0, 1'b0);
    run_burst(1, 32'h125, BYTE, WRAP8, 1'b0, 1'b1);   // byte wrap in 0x120..0x127
    run_burst(0, 32'h120, WORD, INCR4, 1'b0, 1'b0);
    report_test("burst");

    // both request in the same cycle
    fork
      run_burst(0, 32'h180, WORD, INCR4, 1'b0, 1'b1);
      run_burst(1, 32'h100, WORD, INCR4, 1'b0, 1'b0);
    join
    check_val("port0_first", 32'd1, {31'b0, acc_time[0] < acc_time[1]});
    check_val("port1_after_port0", 32'd1, {31'b0, acc_time[1] > done_time[0]});
    run_burst(1, 32'h180, WORD, INCR4, 1'b0, 1'b0);
    report_test("arbiter");

    run_burst(0, 32'h400, WORD, SINGLE, 1'b1, 1'b0);  // past the ram
    run_burst(1, 32'h400, WORD, INCR4, 1'b1, 1'b1);
    run_burst(0, 32'h300, WORD, SINGLE, 1'b1, 1'b1);  // privileged, succeeds
    run_burst(1, 32'h300, WORD, SINGLE, 1'b0, 1'b1);  // refused, no update
    run_burst(1, 32'h300, WORD, SINGLE, 1'b0, 1'b0);
    run_burst(0, 32'h300, WORD, SINGLE, 1'b1, 1'b0);  // still the first value
    run_burst(0, 32'h000, DWORD, SINGLE, 1'b1, 1'b0);
    run_burst(1, 32'h008, DWORD, SINGLE, 1'b1, 1'b1);
    report_test("errors");

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+test
source/biu_pkg.sv
source/biu_mux.sv
source/biu_apb_bridge.sv
source/apb_ram.sv
source/biu_subsys_top.sv
test/biu_subsys_tb.sv
